//--- mips_cpu_bus.f
logic/mips_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/cpu_sequencer.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/exec_unit.sv
logic/pc_unit.sv
logic/mips_cpu_bus.sv
verification/tb_avalon_memory.sv
verification/tb_mips_cpu_bus.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_mips_cpu_bus
FILELIST  = mips_cpu_bus.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_mips_cpu_bus.sv
`timescale 1ns/10ps

module tb_mips_cpu_bus;

  localparam cpu_bus_pkg::word_t rv   = cpu_bus_pkg::reset_vector_default;
  localparam cpu_bus_pkg::word_t sub1 = rv + 32'h200;  // jal / jr routine
  localparam cpu_bus_pkg::word_t sub2 = rv + 32'h220;  // jalr routine
  localparam cpu_bus_pkg::word_t tail = rv + 32'h240;  // j target, leaves through jr $zero

  logic                  clk, reset, active, write, read, waitrequest;
  cpu_bus_pkg::word_t    register_v0, address, writedata, readdata;
  logic [3:0]            byteenable;
  cpu_bus_pkg::bus_req_t mem_req;

  // reference machine state
  cpu_bus_pkg::word_t ref_regs [32];
  cpu_bus_pkg::word_t ref_mem [cpu_bus_pkg::word_t];
  cpu_bus_pkg::word_t ref_pc, ref_target, exp_addr, exp_wdata, cur_pc, next_addr;
  logic               ref_delay, exp_load, exp_store, halted;
  int                 cycle_count = 0;
  int                 cycle_limit = 0;
  int                 prog_len = 0;

  mips_cpu_bus #(.reset_vector(rv)) u_dut (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .address(address), .write(write), .read(read), .waitrequest(waitrequest),
    .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
  );

  assign mem_req = {address, writedata, read, write, byteenable};

  tb_avalon_memory u_mem (.clk(clk), .req(mem_req), .waitrequest(waitrequest),
                          .readdata(readdata));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_word(input string name, input cpu_bus_pkg::word_t got,
                            input cpu_bus_pkg::word_t exp);
    assert (got === exp) else begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, got);
      stop_on_failure("value mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, got);
      stop_on_failure("value mismatch");
    end
  endtask

  // encoders for the test program
  function automatic cpu_bus_pkg::word_t r_op(input logic [5:0] fn, input logic [4:0] rs,
      input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
    return {6'd0, rs, rt, rd, sh, fn};
  endfunction

  function automatic cpu_bus_pkg::word_t i_op(input logic [5:0] op, input logic [4:0] rs,
      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpu_bus_pkg::word_t j_op(input logic [5:0] op,
      input cpu_bus_pkg::word_t target);
    return {op, target[27:2]};
  endfunction

  function automatic cpu_bus_pkg::word_t ref_word(input cpu_bus_pkg::word_t a);
    return ref_mem.exists(a) ? ref_mem[a] : 32'h0;
  endfunction

  task automatic place(input cpu_bus_pkg::word_t a, input cpu_bus_pkg::word_t w);
    ref_mem[a] = w;
    u_mem.store_word(a, w);
    prog_len++;
  endtask

  // emit at next_addr and step on
  task automatic emit(input cpu_bus_pkg::word_t w);
    place(next_addr, w);
    next_addr = next_addr + 32'd4;
  endtask

  // one mips32 instruction on the reference state, delayed branches included
  function automatic void iss_step(input cpu_bus_pkg::word_t iw);
    logic [5:0]         op, fn;
    logic [4:0]         rs, rt, rd, sh, dst;
    cpu_bus_pkg::word_t a, b, simm, zimm, res, tgt, npc;
    logic               wr, redirect;
    op = iw[31:26];
    fn = iw[5:0];
    rs = iw[25:21];
    rt = iw[20:16];
    rd = iw[15:11];
    sh = iw[10:6];
    a = ref_regs[rs];
    b = ref_regs[rt];
    simm = {{16{iw[15]}}, iw[15:0]};
    zimm = {16'h0, iw[15:0]};
    wr = 1'b0;
    dst = rt;
    res = '0;
    redirect = 1'b0;
    tgt = '0;
    exp_load = 1'b0;
    exp_store = 1'b0;
    exp_addr = '0;
    exp_wdata = '0;
    case (op)
      mips_isa_pkg::op_special: begin
        wr = 1'b1;
        dst = rd;
        case (fn)
          mips_isa_pkg::fn_addu: res = a + b;
          mips_isa_pkg::fn_subu: res = a - b;
          mips_isa_pkg::fn_and:  res = a & b;
          mips_isa_pkg::fn_or:   res = a | b;
          mips_isa_pkg::fn_xor:  res = a ^ b;
          mips_isa_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mips_isa_pkg::fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
          mips_isa_pkg::fn_sll:  res = b << sh;
          mips_isa_pkg::fn_srl:  res = b >> sh;
          mips_isa_pkg::fn_sra:  res = $unsigned($signed(b) >>> sh);
          mips_isa_pkg::fn_jr: begin
            wr = 1'b0;
            redirect = 1'b1;
            tgt = a;
          end
          mips_isa_pkg::fn_jalr: begin
            res = ref_pc + 32'd8;  // link past the delay slot
            redirect = 1'b1;
            tgt = a;
          end
          default: wr = 1'b0;
        endcase
      end
      mips_isa_pkg::op_addiu: begin
        wr = 1'b1;
        res = a + simm;
      end
      mips_isa_pkg::op_slti: begin
        wr = 1'b1;
        res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      end
      mips_isa_pkg::op_sltiu: begin
        wr = 1'b1;
        res = (a < simm) ? 32'd1 : 32'd0;
      end
      mips_isa_pkg::op_andi: begin
        wr = 1'b1;
        res = a & zimm;
      end
      mips_isa_pkg::op_ori: begin
        wr = 1'b1;
        res = a | zimm;
      end
      mips_isa_pkg::op_xori: begin
        wr = 1'b1;
        res = a ^ zimm;
      end
      mips_isa_pkg::op_lui: begin
        wr = 1'b1;
        res = {iw[15:0], 16'h0};
      end
      mips_isa_pkg::op_lw: begin
        exp_load = 1'b1;
        exp_addr = a + simm;
        wr = 1'b1;
        res = ref_word(exp_addr);
      end
      mips_isa_pkg::op_sw: begin
        exp_store = 1'b1;
        exp_addr = a + simm;
        exp_wdata = b;
        ref_mem[exp_addr] = b;
      end
      mips_isa_pkg::op_beq, mips_isa_pkg::op_bne: begin
        redirect = (a == b) ^ (op == mips_isa_pkg::op_bne);
        tgt = ref_pc + 32'd4 + {simm[29:0], 2'b00};
      end
      mips_isa_pkg::op_j, mips_isa_pkg::op_jal: begin
        redirect = 1'b1;
        tgt = ref_pc + 32'd4;  // region of the delay slot
        tgt[27:0] = {iw[25:0], 2'b00};
        if (op == mips_isa_pkg::op_jal) begin
          wr = 1'b1;
          dst = 5'd31;
          res = ref_pc + 32'd8;
        end
      end
      default: ;  // unknown encodings do nothing
    endcase
    if (wr && dst != 5'd0) ref_regs[dst] = res;
    npc = ref_delay ? ref_target : ref_pc + 32'd4;
    ref_delay = redirect;
    if (redirect) ref_target = tgt;
    ref_pc = npc;
  endfunction

  task automatic load_program();
    next_addr = rv;
    emit(i_op(mips_isa_pkg::op_lui, 0, 8, 16'h1234));
    emit(i_op(mips_isa_pkg::op_ori, 8, 8, 16'h5678));
    emit(r_op(mips_isa_pkg::fn_addu, 8, 0, 2, 0));       // v0 = t0
    emit(i_op(mips_isa_pkg::op_addiu, 0, 9, 16'hFFFB));  // t1 = -5
    emit(r_op(mips_isa_pkg::fn_addu, 9, 0, 2, 0));
    emit(r_op(mips_isa_pkg::fn_addu, 8, 9, 2, 0));
    emit(r_op(mips_isa_pkg::fn_subu, 8, 9, 2, 0));
    emit(r_op(mips_isa_pkg::fn_and, 8, 9, 2, 0));
    emit(r_op(mips_isa_pkg::fn_or, 8, 9, 2, 0));
    emit(r_op(mips_isa_pkg::fn_xor, 8, 9, 2, 0));
    emit(r_op(mips_isa_pkg::fn_slt, 9, 8, 2, 0));
    emit(r_op(mips_isa_pkg::fn_sltu, 9, 8, 2, 0));
    emit(r_op(mips_isa_pkg::fn_sll, 0, 9, 2, 4));
    emit(r_op(mips_isa_pkg::fn_srl, 0, 9, 2, 4));
    emit(r_op(mips_isa_pkg::fn_sra, 0, 9, 2, 4));
    emit(i_op(mips_isa_pkg::op_addiu, 9, 2, 16'd100));
    emit(i_op(mips_isa_pkg::op_andi, 9, 2, 16'hF0F0));
    emit(i_op(mips_isa_pkg::op_xori, 8, 2, 16'hFFFF));
    emit(i_op(mips_isa_pkg::op_slti, 9, 2, 16'hFFFD));
    emit(i_op(mips_isa_pkg::op_sltiu, 9, 2, 16'hFFFD));  // compares as unsigned
    emit(i_op(mips_isa_pkg::op_lui, 0, 2, 16'hBEEF));
    // stores and loads around 0x100
    emit(i_op(mips_isa_pkg::op_addiu, 0, 16, 16'h0100));
    emit(i_op(mips_isa_pkg::op_sw, 16, 8, 16'd0));
    emit(i_op(mips_isa_pkg::op_sw, 16, 9, 16'd4));
    emit(i_op(mips_isa_pkg::op_lw, 16, 10, 16'd4));
    emit(r_op(mips_isa_pkg::fn_addu, 10, 0, 2, 0));
    emit(i_op(mips_isa_pkg::op_lw, 16, 2, 16'd0));
    // branches, each followed by its delay slot
    emit(i_op(mips_isa_pkg::op_beq, 8, 9, 16'd2));       // not taken
    emit(i_op(mips_isa_pkg::op_addiu, 0, 2, 16'd1));
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd1));
    emit(i_op(mips_isa_pkg::op_bne, 8, 9, 16'd2));       // taken
    emit(i_op(mips_isa_pkg::op_addiu, 0, 2, 16'd7));
    emit(i_op(mips_isa_pkg::op_addiu, 0, 2, 16'd99));    // skipped
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd1));
    emit(i_op(mips_isa_pkg::op_beq, 8, 8, 16'd2));       // taken
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd3));
    emit(i_op(mips_isa_pkg::op_addiu, 0, 2, 16'd55));    // skipped
    emit(i_op(mips_isa_pkg::op_bne, 8, 8, 16'd2));       // not taken
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd2));
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd5));
    // calls
    emit(j_op(mips_isa_pkg::op_jal, sub1));
    emit(i_op(mips_isa_pkg::op_addiu, 0, 2, 16'd3));
    emit(r_op(mips_isa_pkg::fn_addu, 31, 0, 2, 0));      // v0 = ra
    emit(i_op(mips_isa_pkg::op_lui, 0, 17, sub2[31:16]));
    emit(i_op(mips_isa_pkg::op_ori, 17, 17, sub2[15:0]));
    emit(r_op(mips_isa_pkg::fn_jalr, 17, 0, 11, 0));     // t3 = link
    emit(32'h0);
    emit(j_op(mips_isa_pkg::op_j, tail));
    emit(32'h0);
    next_addr = sub1;
    emit(r_op(mips_isa_pkg::fn_jr, 31, 0, 0, 0));
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd5));
    next_addr = sub2;
    emit(r_op(mips_isa_pkg::fn_addu, 11, 0, 2, 0));
    emit(r_op(mips_isa_pkg::fn_jr, 11, 0, 0, 0));
    emit(32'h0);
    next_addr = tail;
    emit(i_op(mips_isa_pkg::op_addiu, 0, 2, 16'h42));
    emit(r_op(mips_isa_pkg::fn_jr, 0, 0, 0, 0));         // off to address 0
    emit(i_op(mips_isa_pkg::op_addiu, 2, 2, 16'd1));
    place(cpu_bus_pkg::halt_address, 32'h0);             // last word executed
  endtask

  task automatic check_idle(input string where);
    check_bit({where, " read"}, read, 1'b0);
    check_bit({where, " write"}, write, 1'b0);
  endtask

  initial begin
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    ref_pc = rv;
    ref_delay = 1'b0;
    ref_target = '0;
    halted = 1'b0;
    reset = 1'b1;
    load_program();
    cycle_limit = 16 + 1 + 20 + (prog_len + 8) * (4 + 2 * 3) + 100;
    repeat (15) begin
      @(negedge clk);
      check_idle("reset");
    end
    @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);  // one idle cycle before the first fetch
    check_idle("start");
    check_bit("active", active, 1'b1);
    while (!halted) begin
      @(negedge clk);  // fetch
      check_bit("read", read, 1'b1);
      check_bit("write", write, 1'b0);
      check_word("address", address, ref_pc);
      check_word("register_v0", register_v0, ref_regs[2]);
      check_bit("active", active, 1'b1);
      do begin  // load, address held while stalled
        @(negedge clk);
        check_bit("read", read, 1'b1);
        check_bit("write", write, 1'b0);
        check_word("address", address, ref_pc);
      end while (waitrequest);
      cur_pc = ref_pc;
      iss_step(ref_word(cur_pc));
      if (exp_load || exp_store) begin
        do begin
          @(negedge clk);
          check_bit("read", read, exp_load);
          check_bit("write", write, exp_store);
          check_word("address", address, exp_addr);
          check_word("byteenable", {28'h0, byteenable}, 32'hF);
          if (exp_store) check_word("writedata", writedata, exp_wdata);
        end while (waitrequest);
      end else begin
        @(negedge clk);
        check_idle("mem");
      end
      @(negedge clk);  // exec
      check_idle("exec");
      if (cur_pc == cpu_bus_pkg::halt_address) halted = 1'b1;
    end
    repeat (20) begin
      @(negedge clk);
      check_idle("halted");
      check_bit("active", active, 1'b0);
    end
    check_word("register_v0", register_v0, ref_regs[2]);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // run limit from the program length and the worst stall per access
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_on_failure("timeout, the processor did not reach the halt address in time");
  end

endmodule

//--- verification/tb_avalon_memory.sv
`timescale 1ns/10ps

module tb_avalon_memory (
  input  logic                  clk,
  input  cpu_bus_pkg::bus_req_t req,
  output logic                  waitrequest,
  output cpu_bus_pkg::word_t    readdata
);

  cpu_bus_pkg::word_t mem [512];  // lower half near 0, upper half at the boot rom
  logic [15:0]        lfsr = 16'd77;
  logic [1:0]         stall_left = 2'd0;  // stall cycles before the current access completes

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [8:0] word_index(input cpu_bus_pkg::word_t a);
    return {a[31], a[9:2]};
  endfunction

  task automatic store_word(input cpu_bus_pkg::word_t a, input cpu_bus_pkg::word_t d);
    mem[word_index(a)] = d;
  endtask

  assign waitrequest = (req.read | req.write) && (stall_left != 2'd0);
  assign readdata    = mem[word_index(req.address)];  // valid when waitrequest drops

  always @(posedge clk) begin
    cpu_bus_pkg::bus_req_t seen;
    logic                  held;
    logic                  bit0;
    seen = req;         // sampled at the edge
    held = waitrequest;
    #1;
    if (seen.read || seen.write) begin
      if (held) begin
        stall_left = stall_left - 2'd1;
      end else begin
        if (seen.write) mem[word_index(seen.address)] = seen.writedata;
        bit0 = lfsr[0];  // one lfsr step per bit of the next stall count
        lfsr = lfsr_next(lfsr);
        stall_left = {lfsr[0], bit0};
        lfsr = lfsr_next(lfsr);
      end
    end
  end

endmodule

//--- logic/mips_cpu_bus.sv
`timescale 1ns/10ps

module mips_cpu_bus #(
  parameter cpu_bus_pkg::word_t reset_vector = cpu_bus_pkg::reset_vector_default
) (
  input  logic               clk,
  input  logic               reset,
  output logic               active,
  output cpu_bus_pkg::word_t register_v0,

  // avalon-mm master
  output cpu_bus_pkg::word_t address,
  output logic               write,
  output logic               read,
  input  logic               waitrequest,
  output cpu_bus_pkg::word_t writedata,
  output logic [3:0]         byteenable,
  input  cpu_bus_pkg::word_t readdata
);

  cpu_bus_pkg::bus_req_t bus_req;
  mips_isa_pkg::instr_t  instr;
  mips_isa_pkg::ctrl_t   ctrl;
  cpu_bus_pkg::word_t    pc, pc_plus8;
  cpu_bus_pkg::word_t    rs_data, rt_data;
  cpu_bus_pkg::word_t    data_address, store_data, load_data, write_data;
  logic [4:0]            dest_reg;
  logic                  equal;
  logic                  exec_step;

  // request struct fanned out onto the bus pins
  assign address    = bus_req.address;
  assign writedata  = bus_req.writedata;
  assign read       = bus_req.read;
  assign write      = bus_req.write;
  assign byteenable = bus_req.byteenable;

  cpu_sequencer u_sequencer (
    .clk(clk), .reset(reset),
    .waitrequest(waitrequest), .readdata(readdata),
    .ctrl(ctrl), .pc(pc),
    .data_address(data_address), .store_data(store_data),
    .bus_req(bus_req), .instr(instr), .load_data(load_data),
    .exec_step(exec_step), .active(active)
  );

  instr_decoder u_decoder (.instr(instr), .ctrl(ctrl));

  register_file u_regs (
    .clk(clk), .reset(reset), .exec_step(exec_step),
    .rs_addr(instr.r.rs), .rt_addr(instr.r.rt), .rd_addr(dest_reg),
    .write_data(write_data), .write_enable(ctrl.reg_write),
    .rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
  );

  exec_unit u_exec (
    .instr(instr), .ctrl(ctrl),
    .rs_data(rs_data), .rt_data(rt_data),
    .load_data(load_data), .pc_plus8(pc_plus8),
    .dest_reg(dest_reg), .write_data(write_data),
    .data_address(data_address), .store_data(store_data),
    .equal(equal)
  );

  pc_unit #(.reset_vector(reset_vector)) u_pc (
    .clk(clk), .reset(reset), .exec_step(exec_step),
    .instr(instr), .ctrl(ctrl), .rs_data(rs_data), .equal(equal),
    .pc(pc), .pc_plus8(pc_plus8)
  );

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/10ps

module pc_unit #(
  parameter cpu_bus_pkg::word_t reset_vector = cpu_bus_pkg::reset_vector_default
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 exec_step,
  input  mips_isa_pkg::instr_t instr,
  input  mips_isa_pkg::ctrl_t  ctrl,
  input  cpu_bus_pkg::word_t   rs_data,
  input  logic                 equal,
  output cpu_bus_pkg::word_t   pc,
  output cpu_bus_pkg::word_t   pc_plus8
);

  cpu_bus_pkg::word_t pc_plus4, branch_target, jump_target, next_target;
  cpu_bus_pkg::word_t target_hold;  // where to go after the delay slot
  logic               taken, redirect;
  logic               delay;        // current instruction is a delay slot

  assign pc_plus4      = pc + 32'd4;
  assign pc_plus8      = pc + 32'd8;  // link value
  assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.index, 2'b00};

  assign taken    = ctrl.branch & (equal ^ ctrl.branch_ne);
  assign redirect = taken | ctrl.jump | ctrl.jump_reg;

  assign next_target = ctrl.jump_reg ? rs_data
                     : ctrl.jump     ? jump_target
                     : branch_target;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= reset_vector;
      delay <= 1'b0;
    end else if (exec_step) begin
      pc    <= delay ? target_hold : pc_plus4;  // slot done, take the held target
      delay <= redirect;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_step && redirect) target_hold <= next_target;
  end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
  input  mips_isa_pkg::instr_t instr,
  input  mips_isa_pkg::ctrl_t  ctrl,
  input  cpu_bus_pkg::word_t   rs_data,
  input  cpu_bus_pkg::word_t   rt_data,
  input  cpu_bus_pkg::word_t   load_data,
  input  cpu_bus_pkg::word_t   pc_plus8,
  output logic [4:0]           dest_reg,
  output cpu_bus_pkg::word_t   write_data,
  output cpu_bus_pkg::word_t   data_address,
  output cpu_bus_pkg::word_t   store_data,
  output logic                 equal
);

  cpu_bus_pkg::word_t imm_ext, operand_b, alu_result;
  logic [4:0]         shamt;

  assign shamt     = instr.r.shamt;
  assign imm_ext   = ctrl.imm_zero_ext ? {16'h0000, instr.i.imm}
                                       : {{16{instr.i.imm[15]}}, instr.i.imm};
  assign operand_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  always_comb begin
    case (ctrl.alu_op)
      mips_isa_pkg::alu_add:  alu_result = rs_data + operand_b;  // no overflow trap
      mips_isa_pkg::alu_sub:  alu_result = rs_data - operand_b;
      mips_isa_pkg::alu_and:  alu_result = rs_data & operand_b;
      mips_isa_pkg::alu_or:   alu_result = rs_data | operand_b;
      mips_isa_pkg::alu_xor:  alu_result = rs_data ^ operand_b;
      mips_isa_pkg::alu_slt:  alu_result = {31'd0, $signed(rs_data) < $signed(operand_b)};
      mips_isa_pkg::alu_sltu: alu_result = {31'd0, rs_data < operand_b};
      mips_isa_pkg::alu_sll:  alu_result = operand_b << shamt;
      mips_isa_pkg::alu_srl:  alu_result = operand_b >> shamt;
      mips_isa_pkg::alu_sra:  alu_result = $unsigned($signed(operand_b) >>> shamt);
      mips_isa_pkg::alu_lui:  alu_result = {instr.i.imm, 16'h0000};
      default:                alu_result = '0;
    endcase
  end

  assign data_address = {alu_result[31:2], 2'b00};  // word aligned, low bits dropped
  assign store_data   = rt_data;
  assign equal        = (rs_data == rt_data);       // beq/bne test

  // link wins over load, load over alu
  assign write_data = ctrl.link     ? pc_plus8
                    : ctrl.mem_read ? load_data
                    : alu_result;

  always_comb begin
    case (ctrl.dest_sel)
      mips_isa_pkg::dest_rd:  dest_reg = instr.r.rd;
      mips_isa_pkg::dest_r31: dest_reg = 5'd31;  // $ra
      default:                dest_reg = instr.r.rt;
    endcase
  end

endmodule

//--- logic/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               exec_step,
  input  logic [4:0]         rs_addr,
  input  logic [4:0]         rt_addr,
  input  logic [4:0]         rd_addr,
  input  cpu_bus_pkg::word_t write_data,
  input  logic               write_enable,
  output cpu_bus_pkg::word_t rs_data,
  output cpu_bus_pkg::word_t rt_data,
  output cpu_bus_pkg::word_t register_v0
);

  cpu_bus_pkg::word_t regs [32];

  assign rs_data     = regs[rs_addr];  // combinational read ports
  assign rt_data     = regs[rt_addr];
  assign register_v0 = regs[2];        // $v0 tap for debug

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (exec_step && write_enable && rd_addr != 5'd0) begin
      regs[rd_addr] <= write_data;  // $zero is never written
    end
  end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  mips_isa_pkg::instr_t instr,
  output mips_isa_pkg::ctrl_t  ctrl
);

  // r-type result into rd
  function automatic mips_isa_pkg::ctrl_t r_alu(input mips_isa_pkg::alu_op_e op);
    mips_isa_pkg::ctrl_t c;
    c           = '0;
    c.alu_op    = op;
    c.dest_sel  = mips_isa_pkg::dest_rd;
    c.reg_write = 1'b1;
    return c;
  endfunction

  // i-type result into rt
  function automatic mips_isa_pkg::ctrl_t i_alu(input mips_isa_pkg::alu_op_e op,
                                                input logic zero_ext);
    mips_isa_pkg::ctrl_t c;
    c              = '0;
    c.alu_op       = op;
    c.alu_src_imm  = 1'b1;
    c.imm_zero_ext = zero_ext;
    c.dest_sel     = mips_isa_pkg::dest_rt;
    c.reg_write    = 1'b1;
    return c;
  endfunction

  always_comb begin
    ctrl = '0;  // unknown encodings fall through as a no-op
    case (instr.r.opcode)
      mips_isa_pkg::op_special: begin
        case (instr.r.funct)
          mips_isa_pkg::fn_addu: ctrl = r_alu(mips_isa_pkg::alu_add);
          mips_isa_pkg::fn_subu: ctrl = r_alu(mips_isa_pkg::alu_sub);
          mips_isa_pkg::fn_and:  ctrl = r_alu(mips_isa_pkg::alu_and);
          mips_isa_pkg::fn_or:   ctrl = r_alu(mips_isa_pkg::alu_or);
          mips_isa_pkg::fn_xor:  ctrl = r_alu(mips_isa_pkg::alu_xor);
          mips_isa_pkg::fn_slt:  ctrl = r_alu(mips_isa_pkg::alu_slt);
          mips_isa_pkg::fn_sltu: ctrl = r_alu(mips_isa_pkg::alu_sltu);
          mips_isa_pkg::fn_sll:  ctrl = r_alu(mips_isa_pkg::alu_sll);  // also the canonical nop
          mips_isa_pkg::fn_srl:  ctrl = r_alu(mips_isa_pkg::alu_srl);
          mips_isa_pkg::fn_sra:  ctrl = r_alu(mips_isa_pkg::alu_sra);
          mips_isa_pkg::fn_jr:   ctrl.jump_reg = 1'b1;
          mips_isa_pkg::fn_jalr: begin
            ctrl           = r_alu(mips_isa_pkg::alu_add);
            ctrl.link      = 1'b1;  // rd gets pc+8
            ctrl.jump_reg  = 1'b1;
          end
          default: ;
        endcase
      end
      mips_isa_pkg::op_addiu: ctrl = i_alu(mips_isa_pkg::alu_add, 1'b0);
      mips_isa_pkg::op_slti:  ctrl = i_alu(mips_isa_pkg::alu_slt, 1'b0);
      mips_isa_pkg::op_sltiu: ctrl = i_alu(mips_isa_pkg::alu_sltu, 1'b0);  // still sign-extended
      mips_isa_pkg::op_andi:  ctrl = i_alu(mips_isa_pkg::alu_and, 1'b1);
      mips_isa_pkg::op_ori:   ctrl = i_alu(mips_isa_pkg::alu_or, 1'b1);
      mips_isa_pkg::op_xori:  ctrl = i_alu(mips_isa_pkg::alu_xor, 1'b1);
      mips_isa_pkg::op_lui:   ctrl = i_alu(mips_isa_pkg::alu_lui, 1'b0);
      mips_isa_pkg::op_lw: begin
        ctrl          = i_alu(mips_isa_pkg::alu_add, 1'b0);  // base + offset
        ctrl.mem_read = 1'b1;
      end
      mips_isa_pkg::op_sw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      mips_isa_pkg::op_beq: ctrl.branch = 1'b1;
      mips_isa_pkg::op_bne: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = 1'b1;
      end
      mips_isa_pkg::op_j: ctrl.jump = 1'b1;
      mips_isa_pkg::op_jal: begin
        ctrl.jump      = 1'b1;
        ctrl.link      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dest_sel  = mips_isa_pkg::dest_r31;
      end
      default: ;
    endcase
  end

endmodule

//--- logic/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  waitrequest,
  input  cpu_bus_pkg::word_t    readdata,
  input  mips_isa_pkg::ctrl_t   ctrl,
  input  cpu_bus_pkg::word_t    pc,
  input  cpu_bus_pkg::word_t    data_address,
  input  cpu_bus_pkg::word_t    store_data,
  output cpu_bus_pkg::bus_req_t bus_req,
  output mips_isa_pkg::instr_t  instr,
  output cpu_bus_pkg::word_t    load_data,  // lw result held into exec
  output logic                  exec_step,
  output logic                  active
);

  cpu_bus_pkg::state_e state;
  logic                mem_access;
  logic                accepted;  // bus access completes this cycle

  assign mem_access = ctrl.mem_read | ctrl.mem_write;
  assign accepted   = ~waitrequest;
  assign exec_step  = (state == cpu_bus_pkg::st_exec);

  // request is a pure function of state, pc and the decoded instruction,
  // so it stays put for as long as waitrequest holds the state
  always_comb begin
    bus_req            = '0;
    bus_req.byteenable = 4'hF;  // word accesses only
    bus_req.writedata  = store_data;
    bus_req.address    = pc;
    case (state)
      cpu_bus_pkg::st_fetch, cpu_bus_pkg::st_load: bus_req.read = 1'b1;
      cpu_bus_pkg::st_mem: begin
        bus_req.address = data_address;
        bus_req.read    = ctrl.mem_read;
        bus_req.write   = ctrl.mem_write;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= cpu_bus_pkg::st_halted;  // idle bus while reset is high
      active <= 1'b1;
    end else begin
      case (state)
        cpu_bus_pkg::st_fetch: state <= cpu_bus_pkg::st_load;
        cpu_bus_pkg::st_load: if (accepted) state <= cpu_bus_pkg::st_mem;
        cpu_bus_pkg::st_mem: if (!mem_access || accepted) state <= cpu_bus_pkg::st_exec;
        cpu_bus_pkg::st_exec: begin
          if (pc == cpu_bus_pkg::halt_address) begin  // word at 0 just ran
            state  <= cpu_bus_pkg::st_halted;
            active <= 1'b0;
          end else begin
            state <= cpu_bus_pkg::st_fetch;
          end
        end
        cpu_bus_pkg::st_halted: if (active) state <= cpu_bus_pkg::st_fetch;  // out of reset
        default: state <= cpu_bus_pkg::st_halted;
      endcase
    end
  end

  // instruction and load data registers, captured on the accepted cycle
  always_ff @(posedge clk) begin
    if (state == cpu_bus_pkg::st_load && accepted) instr <= readdata;
    if (state == cpu_bus_pkg::st_mem && ctrl.mem_read && accepted) load_data <= readdata;
  end

endmodule

//--- logic/cpu_bus_pkg.sv
package cpu_bus_pkg;

  typedef logic [31:0] word_t;

  // one instruction at a time walks through these
  typedef enum logic [2:0] {
    st_fetch  = 3'd0,  // put pc on the bus
    st_load   = 3'd1,  // wait for the instruction word
    st_mem    = 3'd2,  // data access for lw/sw, single pass otherwise
    st_exec   = 3'd3,  // register write and pc update
    st_halted = 3'd4   // also the state held during reset
  } state_e;

  // avalon-mm master request, 70 bits
  typedef struct packed {
    word_t      address;
    word_t      writedata;
    logic       read;
    logic       write;
    logic [3:0] byteenable;
  } bus_req_t;

  // mips boot rom location
  localparam word_t reset_vector_default = 32'hBFC00000;

  // cpu stops after executing the word here
  localparam word_t halt_address = 32'h00000000;

endpackage

//--- logic/mips_isa_pkg.sv
package mips_isa_pkg;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'd0,  // r-type, decoded further by funct
    op_j       = 6'd2,
    op_jal     = 6'd3,
    op_beq     = 6'd4,
    op_bne     = 6'd5,
    op_addiu   = 6'd9,
    op_slti    = 6'd10,
    op_sltiu   = 6'd11,
    op_andi    = 6'd12,
    op_ori     = 6'd13,
    op_xori    = 6'd14,
    op_lui     = 6'd15,
    op_lw      = 6'd35,
    op_sw      = 6'd43
  } opcode_e;

  // function codes under op_special, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll  = 6'd0,
    fn_srl  = 6'd2,
    fn_sra  = 6'd3,
    fn_jr   = 6'd8,
    fn_jalr = 6'd9,
    fn_addu = 6'd33,
    fn_subu = 6'd35,
    fn_and  = 6'd36,
    fn_or   = 6'd37,
    fn_xor  = 6'd38,
    fn_slt  = 6'd42,
    fn_sltu = 6'd43
  } funct_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu,     // signed / unsigned set-on-less-than
    alu_sll, alu_srl, alu_sra,  // shift rt by shamt
    alu_lui                // immediate into upper half
  } alu_op_e;

  typedef enum logic [1:0] {
    dest_rt  = 2'd0,  // i-type results and loads
    dest_rd  = 2'd1,  // r-type and jalr
    dest_r31 = 2'd2   // jal link register
  } dest_e;

  // three overlaid views of one instruction word
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] index;  // word index inside the current 256MB region
  } j_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } instr_t;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;   // second operand is the extended immediate
    logic    imm_zero_ext;  // andi/ori/xori
    dest_e   dest_sel;
    logic    reg_write;
    logic    mem_read;      // lw
    logic    mem_write;     // sw
    logic    link;          // write pc+8 back
    logic    branch_ne;     // bne, inverts the equal test
    logic    branch;
    logic    jump;          // j, jal
    logic    jump_reg;      // jr, jalr
  } ctrl_t;

endpackage
